// ==== Makefile ====
# Verilator build and run of the correlator testbench

SRCS := $(wildcard verilog/*.sv testbench/*.sv)

obj_dir/Vtb_correlator: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_correlator \
		-f vlog.f -o Vtb_correlator

run: obj_dir/Vtb_correlator
	./obj_dir/Vtb_correlator +verilator+error+limit+1000 | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== testbench/correlator_properties.sv ====
`timescale 1ns/100ps

// Bus answer and swap pulse timing, bound into correlator_top
module correlator_properties (
   input logic           clk_i,
   input logic           sw_d,
   input logic           enable_i,
   input logic           sample_stb_i,
   input logic           cyc_i,
   input logic           stb_i,
   input corr_pkg::adr_t adr_i,
   input logic           ack_o,
   input logic           err_o,
   input logic           switch_o
);

   int   fail_cnt = 0;  // Failed assertions so far
   logic req;           // Bus request this cycle
   logic mapped;        // Address 0 to 12

   assign req    = cyc_i && stb_i;
   assign mapped = adr_i <= corr_pkg::ADR_BLOCKS;

   // --------------------
   // Bus timing
   // --------------------
   a_ack_after_read: assert property (@(posedge clk_i) disable iff (sw_d)
      req && mapped |-> ##2 (ack_o && !err_o))
      else begin $error("mapped read not acked two cycles later"); fail_cnt++; end

   a_err_after_read: assert property (@(posedge clk_i) disable iff (sw_d)
      req && !mapped |-> ##2 (err_o && !ack_o))
      else begin $error("unmapped read without err two cycles later"); fail_cnt++; end

   // No answer without a matching request
   a_ack_has_req: assert property (@(posedge clk_i) disable iff (sw_d)
      ack_o |-> $past(req && mapped, 2))
      else begin $error("ack without a mapped request"); fail_cnt++; end

   a_err_has_req: assert property (@(posedge clk_i) disable iff (sw_d)
      err_o |-> $past(req && !mapped, 2))
      else begin $error("err without an unmapped request"); fail_cnt++; end

   a_ack_err_excl: assert property (@(posedge clk_i) disable iff (sw_d)
      !(ack_o && err_o))
      else begin $error("ack and err high together"); fail_cnt++; end

   // --------------------
   // Swap timing
   // --------------------
   a_switch_after_stb: assert property (@(posedge clk_i) disable iff (sw_d)
      switch_o |-> $past(sample_stb_i && enable_i, 2))
      else begin $error("switch not two cycles after a strobe"); fail_cnt++; end

   a_switch_one_cycle: assert property (@(posedge clk_i) disable iff (sw_d)
      switch_o |=> !switch_o)
      else begin $error("switch longer than one cycle"); fail_cnt++; end

endmodule

bind correlator_top correlator_properties u_props (
   .clk_i        (clk_i),
   .sw_d         (sw_d),
   .enable_i     (enable_i),
   .sample_stb_i (sample_stb_i),
   .cyc_i        (cyc_i),
   .stb_i        (stb_i),
   .adr_i        (adr_i),
   .ack_o        (ack_o),
   .err_o        (err_o),
   .switch_o     (switch_o)
);

// ==== testbench/tb_correlator.sv ====
`timescale 1ns/100ps

module tb_correlator;

   localparam int CLK_NS    = 10;
   localparam int N_SAMPLES = 37;   // Strobes driven in the whole run
   localparam int N_READS   = 71;   // Bus requests in the whole run
   localparam int LIMIT_NS  = (3*N_SAMPLES + 2*N_READS)*CLK_NS + 2000;

   logic           clk_i = 1'b0;
   logic           sw_d;
   logic           enable_i;
   logic           sample_stb_i;
   corr_pkg::ant_t antenna_i;
   corr_pkg::acc_t blocksize_i;
   logic           cyc_i;
   logic           stb_i;
   corr_pkg::adr_t adr_i;
   logic           ack_o;
   logic           err_o;
   corr_pkg::acc_t dat_o;
   logic           switch_o;

   // Reference model state
   corr_pkg::acc_t m_act  [corr_pkg::NUM_VIS];  // Block being summed
   corr_pkg::acc_t m_done [corr_pkg::NUM_VIS];  // Last finished block
   corr_pkg::acc_t m_cnt;                       // Valid samples in block
   corr_pkg::ant_t m_cur;                       // Last captured word
   logic           m_primed;
   int             m_blocks;

   // Expected answers, index 1 is due at this negedge
   logic           p_req  [2];
   logic           p_err  [2];
   corr_pkg::acc_t p_data [2];

   int errors     = 0;
   int switch_cnt = 0;

   always #(CLK_NS/2) clk_i = ~clk_i;

   correlator_top u_dut (
      .clk_i        (clk_i),
      .sw_d         (sw_d),
      .enable_i     (enable_i),
      .sample_stb_i (sample_stb_i),
      .antenna_i    (antenna_i),
      .blocksize_i  (blocksize_i),
      .cyc_i        (cyc_i),
      .stb_i        (stb_i),
      .adr_i        (adr_i),
      .ack_o        (ack_o),
      .err_o        (err_o),
      .dat_o        (dat_o),
      .switch_o     (switch_o)
   );

   // --------------------
   // Reference model
   // --------------------
   // Real part is the new word, imaginary part the word captured before it
   task automatic model_sample(input corr_pkg::ant_t a);
      int v;
      if (m_primed) begin
         v = 0;
         for (int i = 0; i < corr_pkg::NUM_ANT; i++) begin
            for (int j = i + 1; j < corr_pkg::NUM_ANT; j++) begin  // Pairs in address order
               if (a[i] == a[j]) m_act[v]++;
               if (a[i] == m_cur[j]) m_act[v+1]++;
               v += 2;
            end
         end
         if (m_cnt == blocksize_i) begin          // Last sample of the block
            m_done = m_act;
            for (int k = 0; k < corr_pkg::NUM_VIS; k++) m_act[k] = '0;
            m_cnt = '0;
            m_blocks++;
         end else begin
            m_cnt++;
         end
      end
      m_cur    = a;
      m_primed = 1'b1;
   endtask

   // --------------------
   // Stimulus
   // --------------------
   task automatic drive_samples(input int n);
      corr_pkg::ant_t a;
      for (int s = 0; s < n; s++) begin
         @(posedge clk_i);
         #1;
         a            = corr_pkg::ant_t'($urandom);
         antenna_i    = a;
         sample_stb_i = 1'b1;
         if (enable_i) model_sample(a);  // Disabled strobes are dropped
         @(posedge clk_i);
         #1;
         sample_stb_i = 1'b0;
      end
   endtask

   task automatic set_enable(input logic en);
      @(posedge clk_i);
      #1;
      enable_i = en;
      if (!en) m_primed = 1'b0;           // Delay word goes stale
   endtask

   // One request per cycle, answers drain afterwards
   task automatic read_burst(input int first, input int last);
      @(posedge clk_i);
      #1;
      for (int a = first; a <= last; a++) begin
         cyc_i = 1'b1;
         stb_i = 1'b1;
         adr_i = corr_pkg::adr_t'(a);
         @(posedge clk_i);
         #1;
      end
      cyc_i = 1'b0;
      stb_i = 1'b0;
      repeat (3) @(posedge clk_i);
   endtask

   task automatic wait_switch();
      int n;
      n = 0;
      while (!switch_o && n < 20) begin
         @(negedge clk_i);
         n++;
      end
      assert (switch_o) else begin
         $display("no switch pulse after the last sample of a block");
         errors++;
      end
      @(posedge clk_i);
   endtask

   // --------------------
   // Answer checker
   // --------------------
   always @(negedge clk_i) begin
      if (sw_d) begin
         for (int i = 0; i < 2; i++) p_req[i] = 1'b0;
      end else begin
         assert (ack_o == (p_req[1] && !p_err[1])) else begin
            $display("mismatch at %0t ns: ack_o got %b expected %b",
                     $time, ack_o, p_req[1] && !p_err[1]);
            errors++;
         end
         assert (err_o == (p_req[1] && p_err[1])) else begin
            $display("mismatch at %0t ns: err_o got %b expected %b",
                     $time, err_o, p_req[1] && p_err[1]);
            errors++;
         end
         if (p_req[1] && !p_err[1]) begin
            assert (dat_o == p_data[1]) else begin
               $display("mismatch at %0t ns: dat_o got %0d expected %0d",
                        $time, dat_o, p_data[1]);
               errors++;
            end
         end
         if (switch_o) switch_cnt++;
         p_req[1]  = p_req[0];
         p_err[1]  = p_err[0];
         p_data[1] = p_data[0];
         p_req[0]  = cyc_i && stb_i;             // Sampled at the coming edge
         p_err[0]  = adr_i > corr_pkg::ADR_BLOCKS;
         p_data[0] = '0;
         if (adr_i == corr_pkg::ADR_BLOCKS) p_data[0] = corr_pkg::acc_t'(m_blocks);
         else if (adr_i < corr_pkg::ADR_BLOCKS) p_data[0] = m_done[adr_i];
      end
   end

   // --------------------
   // Test sequence
   // --------------------
   initial begin
      void'($urandom(9845));
      sw_d         = 1'b1;
      enable_i     = 1'b0;
      sample_stb_i = 1'b0;
      antenna_i    = '0;
      blocksize_i  = 16'd15;               // Sixteen samples per block
      cyc_i        = 1'b0;
      stb_i        = 1'b0;
      adr_i        = '0;
      for (int k = 0; k < corr_pkg::NUM_VIS; k++) begin
         m_act[k]  = '0;
         m_done[k] = '0;
      end
      m_cnt    = '0;
      m_cur    = '0;
      m_primed = 1'b0;
      m_blocks = 0;
      repeat (5) @(posedge clk_i);
      #1;
      sw_d = 1'b0;

      repeat (4) @(posedge clk_i);         // Quiet bus after reset
      read_burst(0, 12);                   // All zero

      set_enable(1'b1);
      drive_samples(17);                   // First strobe only primes
      wait_switch();
      read_burst(0, 12);

      drive_samples(6);                    // Next block under way
      set_enable(1'b0);
      drive_samples(3);
      set_enable(1'b1);
      drive_samples(1);                    // Primes again
      read_burst(0, 12);                   // Still the first block
      drive_samples(10);
      wait_switch();
      read_burst(0, 31);                   // Unmapped range too

      assert (switch_cnt == m_blocks) else begin
         $display("mismatch at %0t ns: switch_o pulses got %0d expected %0d",
                  $time, switch_cnt, m_blocks);
         errors++;
      end
      $display("Checks done: %0d testbench errors, %0d assertion failures",
               errors, u_dut.u_props.fail_cnt);
      if (errors == 0 && u_dut.u_props.fail_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(LIMIT_NS);
      errors++;
      $display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
      $display("Checks done: %0d testbench errors, %0d assertion failures",
               errors, u_dut.u_props.fail_cnt);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== verilog/bus_port.sv ====
`timescale 1ns/100ps

// Read-only bus port
// Stage one decodes the request, stage two answers it
module bus_port (
   input  logic           clk_i,
   input  logic           sw_d,   // Async reset, active high
   input  logic           cyc_i,
   input  logic           stb_i,
   input  corr_pkg::adr_t adr_i,
   output logic           ack_o,  // Mapped read done
   output logic           err_o,  // Unmapped address
   output corr_pkg::acc_t dat_o,  // Valid with ack_o
   read_if.port           rd
);

   logic               req;       // Request this cycle
   logic               vis_hit;   // Addresses 0 to 11
   logic               blk_hit;   // Blocks register
   logic               s1_vis_q;
   logic               s1_blk_q;
   logic               s1_err_q;
   corr_pkg::vis_idx_t s1_idx_q;
   logic               s2_blk_q;  // Answer comes from the counter
   corr_pkg::acc_t     blocks_q;  // Completed blocks so far

   assign req     = cyc_i && stb_i;
   assign vis_hit = adr_i < corr_pkg::ADR_BLOCKS;
   assign blk_hit = adr_i == corr_pkg::ADR_BLOCKS;

   // --------------------
   // Stage one, decode
   // --------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         s1_vis_q <= 1'b0;
         s1_blk_q <= 1'b0;
         s1_err_q <= 1'b0;
      end else begin
         s1_vis_q <= req && vis_hit;
         s1_blk_q <= req && blk_hit;
         s1_err_q <= req && !vis_hit && !blk_hit;  // 13 to 31
      end
   end

   always_ff @(posedge clk_i) begin
      s1_idx_q <= adr_i[$bits(corr_pkg::vis_idx_t)-1:0];
   end

   // Bank lookup runs alongside stage two
   assign rd.rd_stb = s1_vis_q;
   assign rd.rd_idx = s1_idx_q;

   // --------------------
   // Stage two, answer
   // --------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         ack_o    <= 1'b0;
         err_o    <= 1'b0;
         s2_blk_q <= 1'b0;
      end else begin
         ack_o    <= s1_vis_q || s1_blk_q;
         err_o    <= s1_err_q;              // Never with ack
         s2_blk_q <= s1_blk_q;
      end
   end

   // Count of finished blocks, one per swap
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         blocks_q <= '0;
      end else if (rd.swap) begin
         blocks_q <= blocks_q + 1'b1;
      end
   end

   assign dat_o = s2_blk_q ? blocks_q : rd.rd_data;  // Tag picks source

endmodule

// ==== verilog/corr_pkg.sv ====
package corr_pkg;

   // --------------------
   // Array and word sizes
   // --------------------
   localparam int NUM_ANT   = 4;            // Antennas, one bit each
   localparam int NUM_PAIRS = 6;            // All baselines of four antennas
   localparam int NUM_VIS   = 2*NUM_PAIRS;  // Real and imaginary word per pair
   localparam int ACC_W     = 16;           // Accumulator width, wraps
   localparam int ADR_W     = 5;            // Bus address width
   localparam int IDX_W     = 4;            // Visibility index width

   // Vectors that carry a meaning
   typedef logic [NUM_ANT-1:0] ant_t;       // One sample bit per antenna
   typedef logic [ACC_W-1:0]   acc_t;       // Visibility sum, bus data word
   typedef logic [ADR_W-1:0]   adr_t;       // Bus address
   typedef logic [IDX_W-1:0]   vis_idx_t;   // Visibility word 0 to 11

   // --------------------
   // Address map
   // --------------------
   // 2p is real of pair p, 2p+1 its imaginary part
   // Everything above the blocks register is unmapped
   localparam adr_t ADR_BLOCKS = 5'd12;     // Completed-blocks count

   // --------------------
   // Pair order
   // --------------------
   // (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
   localparam int PAIR_A [NUM_PAIRS] = '{0, 0, 0, 1, 1, 2};  // First antenna
   localparam int PAIR_B [NUM_PAIRS] = '{1, 2, 3, 2, 3, 3};  // Second antenna

endpackage

// ==== verilog/correlator_top.sv ====
`timescale 1ns/100ps

// Four-antenna correlator, top level
// Sampler feeds the banks, the bus port reads them
module correlator_top (
   input  logic           clk_i,
   input  logic           sw_d,          // Async reset, active high

   // Acquisition
   input  logic           enable_i,      // Acquisition running
   input  logic           sample_stb_i,  // antenna_i is valid
   input  corr_pkg::ant_t antenna_i,     // Real bit per antenna
   input  corr_pkg::acc_t blocksize_i,   // Samples per block minus one

   // Read bus
   input  logic           cyc_i,
   input  logic           stb_i,
   input  corr_pkg::adr_t adr_i,
   output logic           ack_o,
   output logic           err_o,
   output corr_pkg::acc_t dat_o,

   output logic           switch_o       // New block result ready
);

   sample_if smp_if ();  // Sampler to banks
   read_if   rd_if ();   // Bus port to banks

   // --------------------
   // Producer
   // --------------------
   quad_sampler u_sampler (
      .clk_i        (clk_i),
      .sw_d         (sw_d),
      .enable_i     (enable_i),
      .sample_stb_i (sample_stb_i),
      .antenna_i    (antenna_i),
      .smp          (smp_if.sampler)
   );

   // --------------------
   // Buffer
   // --------------------
   visibility_banks u_banks (
      .clk_i       (clk_i),
      .sw_d        (sw_d),
      .blocksize_i (blocksize_i),
      .smp         (smp_if.banks),
      .rd          (rd_if.banks)
   );

   // --------------------
   // Consumer
   // --------------------
   bus_port u_port (
      .clk_i (clk_i),
      .sw_d  (sw_d),
      .cyc_i (cyc_i),
      .stb_i (stb_i),
      .adr_i (adr_i),
      .ack_o (ack_o),
      .err_o (err_o),
      .dat_o (dat_o),
      .rd    (rd_if.port)
   );

   assign switch_o = rd_if.swap;  // Same single clock, no sync needed

endmodule

// ==== verilog/quad_sampler.sv ====
`timescale 1ns/100ps

// Antenna sampler
// Real part is the newest capture, imaginary part the one before it
module quad_sampler (
   input  logic           clk_i,
   input  logic           sw_d,         // Async reset, active high
   input  logic           enable_i,     // Acquisition running
   input  logic           sample_stb_i, // New antenna word present
   input  corr_pkg::ant_t antenna_i,    // One real bit per antenna
   sample_if.sampler      smp
);

   corr_pkg::ant_t cur_q;     // Latest capture
   corr_pkg::ant_t prev_q;    // Capture one sample earlier
   logic           primed_q;  // A previous sample exists
   logic           valid_q;   // Output strobe
   logic           take;      // Capture this cycle

   assign take = enable_i && sample_stb_i;

   // --------------------
   // Control
   // --------------------
   // First strobe after enable rises only fills the delay register,
   // so no valid follows it
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         primed_q <= 1'b0;
         valid_q  <= 1'b0;
      end else if (!enable_i) begin
         primed_q <= 1'b0;                   // Delay line is stale now
         valid_q  <= 1'b0;
      end else begin
         valid_q <= sample_stb_i && primed_q;  // Pulse one cycle later
         if (sample_stb_i) begin
            primed_q <= 1'b1;
         end
      end
   end

   // --------------------
   // Sample registers
   // --------------------
   always_ff @(posedge clk_i) begin
      if (take) begin
         cur_q  <= antenna_i;
         prev_q <= cur_q;                    // One-sample delay
      end
   end

   // Present both parts to the banks
   assign smp.re    = cur_q;
   assign smp.im    = prev_q;
   assign smp.valid = valid_q;

endmodule

// ==== verilog/read_if.sv ====
`timescale 1ns/100ps

// Link from the bus port to the readable bank
interface read_if;

   logic               rd_stb;   // One-cycle read request
   corr_pkg::vis_idx_t rd_idx;   // Which visibility word
   corr_pkg::acc_t     rd_data;  // Valid one cycle after rd_stb
   logic               swap;     // Banks swapped, new result ready

   // Bus side
   modport port (
      output rd_stb,
      output rd_idx,
      input  rd_data,
      input  swap
   );

   // Bank side
   modport banks (
      input  rd_stb,
      input  rd_idx,
      output rd_data,
      output swap
   );

endinterface

// ==== verilog/sample_if.sv ====
`timescale 1ns/100ps

// Link from the sampler to the visibility banks
// One word of real and one of imaginary bits per strobe
interface sample_if;

   corr_pkg::ant_t re;     // Current capture, real part
   corr_pkg::ant_t im;     // Previous capture, stand-in for imaginary
   logic           valid;  // One-cycle pulse per usable sample

   // Producer side
   modport sampler (
      output re,
      output im,
      output valid
   );

   // Consumer side, accumulators
   modport banks (
      input re,
      input im,
      input valid
   );

endinterface

// ==== verilog/visibility_banks.sv ====
`timescale 1ns/100ps

// Double-buffered visibility accumulators
// Active set counts agreements, readable set holds the last finished block
module visibility_banks (
   input  logic           clk_i,
   input  logic           sw_d,        // Async reset, active high
   input  corr_pkg::acc_t blocksize_i, // Samples per block minus one
   sample_if.banks        smp,
   read_if.banks          rd
);

   corr_pkg::acc_t               smp_cnt_q;               // Sample number in block
   logic                         blk_end;                 // Last sample of block
   logic [corr_pkg::NUM_VIS-1:0] hit;                     // Per word increment
   corr_pkg::acc_t               sum    [corr_pkg::NUM_VIS]; // Active plus hit
   corr_pkg::acc_t               act_q  [corr_pkg::NUM_VIS]; // Accumulating bank
   corr_pkg::acc_t               done_q [corr_pkg::NUM_VIS]; // Readable bank
   logic                         swap_q;
   corr_pkg::acc_t               rd_data_q;

   // --------------------
   // Pair correlators
   // --------------------
   // One-bit correlation is an XNOR, agreement counts as one
   for (genvar p = 0; p < corr_pkg::NUM_PAIRS; p++) begin : g_pair
      // Real, re[a] against re[b]
      assign hit[2*p]   = smp.re[corr_pkg::PAIR_A[p]] ~^ smp.re[corr_pkg::PAIR_B[p]];
      // Imaginary, re[a] against delayed re[b]
      assign hit[2*p+1] = smp.re[corr_pkg::PAIR_A[p]] ~^ smp.im[corr_pkg::PAIR_B[p]];
   end

   // Next value of each active word
   for (genvar v = 0; v < corr_pkg::NUM_VIS; v++) begin : g_sum
      assign sum[v] = act_q[v] + {{(corr_pkg::ACC_W-1){1'b0}}, hit[v]};  // Wraps
   end

   // --------------------
   // Block counter
   // --------------------
   assign blk_end = smp.valid && (smp_cnt_q == blocksize_i);

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         smp_cnt_q <= '0;
      end else if (smp.valid) begin
         if (blk_end) begin
            smp_cnt_q <= '0;                 // Start next block
         end else begin
            smp_cnt_q <= smp_cnt_q + 1'b1;
         end
      end
   end

   // --------------------
   // Accumulator banks
   // --------------------
   // On block end the finished sums, last sample included, move to the
   // readable bank and the active bank restarts from zero
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         for (int i = 0; i < corr_pkg::NUM_VIS; i++) begin
            act_q[i]  <= '0;
            done_q[i] <= '0;
         end
      end else if (blk_end) begin
         for (int i = 0; i < corr_pkg::NUM_VIS; i++) begin
            done_q[i] <= sum[i];             // Swap in finished block
            act_q[i]  <= '0;
         end
      end else if (smp.valid) begin
         for (int i = 0; i < corr_pkg::NUM_VIS; i++) begin
            act_q[i] <= sum[i];
         end
      end
   end

   // Swap pulse, high for the cycle after the last accumulate
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         swap_q <= 1'b0;
      end else begin
         swap_q <= blk_end;
      end
   end

   // --------------------
   // Read side
   // --------------------
   // Word is held until the next request
   always_ff @(posedge clk_i) begin
      if (rd.rd_stb && (rd.rd_idx < corr_pkg::NUM_VIS)) begin
         rd_data_q <= done_q[rd.rd_idx];
      end
   end

   assign rd.rd_data = rd_data_q;
   assign rd.swap    = swap_q;

endmodule

// ==== vlog.f ====
verilog/corr_pkg.sv
verilog/sample_if.sv
verilog/read_if.sv
verilog/quad_sampler.sv
verilog/visibility_banks.sv
verilog/bus_port.sv
verilog/correlator_top.sv
testbench/correlator_properties.sv
testbench/tb_correlator.sv
